// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the pipe_core testbench with Verilator
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_pipe_core \
    --Mdir "$build_dir" \
    -o tb_pipe_core_sim

# a failing run still leaves its log for the search below
"./$build_dir/tb_pipe_core_sim" > "$log_file" 2>&1 || true
cat "$log_file"

if grep -qx "SIMULATION PASSED" "$log_file"; then
    exit 0
fi
exit 1

// ==== sources.f ====
verilog/common_pkg.sv
verilog/pipes_pkg.sv
verilog/bypass.sv
verilog/regfile.sv
verilog/alu_lane.sv
verilog/issue_stage.sv
verilog/pipe_core.sv
testbench/pipe_core_properties.sv
testbench/tb_pipe_core.sv

// ==== testbench/pipe_core_properties.sv ====
`default_nettype none

module pipe_core_props import common_pkg::*, pipes_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  retire_t        [lanes-1:0]    retire,
    input  stage_t         [lanes-1:0]    e_q,
    input  stage_t         [lanes-1:0]    m1_q,
    input  stage_t         [lanes-1:0]    m2_q,
    input  bypass_issue_t  [lanes-1:0]    dataI
);

    timeunit 1ns;
    timeprecision 1ps;

    // some held source waits on a mul still in E or M1
    logic late_hit;

    // mul in flight that writes one of the registers read in issue
    function automatic logic is_late(stage_t s, bypass_issue_t rd);
        return s.instr.valid && (s.instr.op == op_mul) && (s.instr.rdst != '0) &&
               ((s.instr.rdst == rd.ra1) || (s.instr.rdst == rd.ra2));
    endfunction

    always_comb begin
        late_hit = 1'b0;
        for (int i = 0; i < lanes; i++) begin
            for (int j = 0; j < lanes; j++) begin
                if (is_late(e_q[i], dataI[j]) || is_late(m1_q[i], dataI[j])) begin
                    late_hit = 1'b1;
                end
            end
        end
    end

    // nothing retires while reset is held
    assert property (@(posedge clk) !rst_n |-> (!retire[0].valid && !retire[1].valid))
        else $error("retire valid while reset is held");

    // a split costs one cycle, longer stalls need a pending mul
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(stall && !late_hit) && !late_hit) |-> !stall)
        else $error("stall held with no late write pending");

    // r0 destinations never show up as retired writes
    assert property (@(posedge clk) disable iff (!rst_n)
        m2_q[0].instr.valid |-> !(retire[0].valid && (retire[0].rdst == '0)))
        else $error("lane 0 retired a write to r0");

    assert property (@(posedge clk) disable iff (!rst_n)
        m2_q[1].instr.valid |-> !(retire[1].valid && (retire[1].rdst == '0)))
        else $error("lane 1 retired a write to r0");

endmodule

bind pipe_core pipe_core_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .retire (retire),
    .e_q    (e_q),
    .m1_q   (m1_q),
    .m2_q   (m2_q),
    .dataI  (dataI)
);

`default_nettype wire

// ==== testbench/tb_pipe_core.sv ====
`default_nettype none

module tb_pipe_core import common_pkg::*, pipes_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int n_dir      = 10;
    localparam int n_rand     = 250;
    // readback of r1..r7 takes four bundles
    localparam int n_instr    = 2 * (n_dir + n_rand + 4);

    logic                clk = 1'b0;
    logic                rst_n;
    logic                in_valid;
    instr_t  [lanes-1:0] in_bundle;
    logic                stall;
    retire_t [lanes-1:0] retire;

    integer  seed;
    int      mism_cnt = 0;
    int      other_cnt = 0;
    int      check_cnt = 0;
    // architectural model and the writes it still expects
    word_t   model_regs [reg_cnt];
    retire_t exp_q [$];

    pipe_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bundle (in_bundle),
        .stall     (stall),
        .retire    (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic instr_t make_instr(op_t op, int rd, int ra1, int ra2, int imm);
        instr_t ins;
        ins.valid = 1'b1;
        ins.op    = op;
        ins.rdst  = creg_addr_t'(rd);
        ins.ra1   = creg_addr_t'(ra1);
        ins.ra2   = creg_addr_t'(ra2);
        ins.imm   = 16'(imm);
        return ins;
    endfunction

    // reference semantics of one instruction
    function automatic word_t golden(instr_t ins, word_t a, word_t b);
        word_t ext;
        ext = {{16{ins.imm[15]}}, ins.imm};
        case (ins.op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_addi: return a + ext;
            // low word of the product
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    // run one accepted instruction on the model, in program order
    task automatic model_accept(instr_t ins);
        retire_t rec;
        word_t   res;
        if (ins.valid) begin
            res = golden(ins, model_regs[ins.ra1], model_regs[ins.ra2]);
            // r0 stays zero and does not retire
            if (ins.rdst != '0) begin
                model_regs[ins.rdst] = res;
                rec.valid = 1'b1;
                rec.rdst  = ins.rdst;
                rec.data  = res;
                exp_q.push_back(rec);
            end
        end
    endtask

    // hold the bundle until stall is low ahead of a rising edge
    task automatic send_bundle(instr_t b0, instr_t b1);
        in_valid     <= 1'b1;
        in_bundle[0] <= b0;
        in_bundle[1] <= b1;
        // stall settles mid cycle, the next edge takes the bundle
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        model_accept(b0);
        model_accept(b1);
    endtask

    // small register range for hazards, mul weighted up
    task automatic draw_instr(output instr_t ins);
        int pick;
        pick      = int'($unsigned($random(seed)) % 10);
        ins.valid = 1'b1;
        ins.op    = (pick >= 7) ? op_mul : op_t'(pick);
        ins.rdst  = creg_addr_t'($unsigned($random(seed)) % 8);
        ins.ra1   = creg_addr_t'($unsigned($random(seed)) % 8);
        ins.ra2   = creg_addr_t'($unsigned($random(seed)) % 8);
        ins.imm   = 16'($random(seed));
    endtask

    // retire checker, lane 0 is the older write
    always @(posedge clk) begin
        retire_t want;
        if (rst_n) begin
            for (int l = 0; l < lanes; l++) begin
                if (retire[l].valid) begin
                    assert (exp_q.size() != 0) else begin
                        other_cnt++;
                        $display("lane %0d retired at %0t with nothing outstanding", l, $time);
                    end
                    if (exp_q.size() != 0) begin
                        want = exp_q.pop_front();
                        check_cnt++;
                        assert (retire[l].rdst == want.rdst) else begin
                            mism_cnt++;
                            $display("ERROR %0t retire[%0d].rdst got %0d expected %0d",
                                     $time, l, retire[l].rdst, want.rdst);
                        end
                        assert (retire[l].data == want.data) else begin
                            mism_cnt++;
                            $display("ERROR %0t retire[%0d].data got %h expected %h",
                                     $time, l, retire[l].data, want.data);
                        end
                    end
                end
            end
        end
    end

    // watchdog scaled by the instruction count
    initial begin
        #(20 * n_instr * clk_period);
        $display("timeout: %0d writes never retired", exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        instr_t b0;
        instr_t b1;
        int     total;
        seed = 94;
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        in_bundle <= '0;
        for (int r = 0; r < reg_cnt; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        assert (!stall && !retire[0].valid && !retire[1].valid) else begin
            other_cnt++;
            $display("stall or retire active during reset at %0t", $time);
        end
        rst_n <= 1'b1;

        // independent writes
        send_bundle(make_instr(op_addi, 1, 0, 0, 5), make_instr(op_addi, 2, 0, 0, -3));
        send_bundle(make_instr(op_addi, 3, 0, 0, 7), make_instr(op_addi, 4, 0, 0, 4660));
        // chain through E, M1 and M2
        send_bundle(make_instr(op_add, 5, 1, 2, 0), make_instr(op_sub, 6, 3, 4, 0));
        send_bundle(make_instr(op_xor, 7, 5, 6, 0), make_instr(op_slt, 1, 6, 5, 0));
        send_bundle(make_instr(op_or, 2, 5, 7, 0), make_instr(op_and, 3, 1, 5, 0));
        // mul with a reader in the same bundle and in the next one
        send_bundle(make_instr(op_mul, 4, 2, 3, 0), make_instr(op_add, 5, 4, 1, 0));
        send_bundle(make_instr(op_mul, 6, 5, 5, 0), make_instr(op_addi, 7, 0, 0, 1));
        send_bundle(make_instr(op_add, 1, 6, 7, 0), make_instr(op_sub, 2, 6, 4, 0));
        // lane 1 reads lane 0's destination
        send_bundle(make_instr(op_addi, 3, 3, 0, 9), make_instr(op_add, 4, 3, 3, 0));
        // r0 write dropped, r0 read gives zero
        send_bundle(make_instr(op_addi, 0, 0, 0, 100), make_instr(op_add, 5, 0, 0, 0));

        for (int n = 0; n < n_rand; n++) begin
            draw_instr(b0);
            draw_instr(b1);
            // now and then a half bundle
            if ($unsigned($random(seed)) % 8 == 0) begin
                b1.valid = 1'b0;
            end
            send_bundle(b0, b1);
        end

        // read back r1..r7 as rX = rX + r0
        for (int r = 1; r < 8; r += 2) begin
            if (r + 1 < 8) begin
                send_bundle(make_instr(op_add, r, r, 0, 0),
                            make_instr(op_add, r + 1, r + 1, 0, 0));
            end else begin
                send_bundle(make_instr(op_add, r, r, 0, 0), '0);
            end
        end
        in_valid  <= 1'b0;
        in_bundle <= '0;

        // drain, then a few idle edges for stray retires
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);

        total = mism_cnt + other_cnt;
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_cnt, mism_cnt, other_cnt);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/alu_lane.sv ====
`default_nettype none

module alu_lane import common_pkg::*, pipes_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  stage_t e_in,
    input  stage_t m1_in,
    output word_t  e_result,
    output word_t  m2_product
);

    // first multiplier stage, filled on the E to M1 edge
    word_t prod_q;
    logic  slt_res;

    // signed compare for slt
    assign slt_res = $signed(e_in.a) < $signed(e_in.b);

    // E stage result
    always_comb begin
        case (e_in.instr.op)
            op_add:  e_result = e_in.a + e_in.b;
            op_sub:  e_result = e_in.a - e_in.b;
            op_and:  e_result = e_in.a & e_in.b;
            op_or:   e_result = e_in.a | e_in.b;
            op_xor:  e_result = e_in.a ^ e_in.b;
            op_slt:  e_result = {{(data_w-1){1'b0}}, slt_res};
            // operand b already holds the immediate
            op_addi: e_result = e_in.a + e_in.b;
            // product not ready yet, marked late in the bypass
            op_mul:  e_result = '0;
            default: e_result = '0;
        endcase
    end

    // two cycle product
    // low word of a*b lines up with the mul in M2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q     <= '0;
            m2_product <= '0;
        end else begin
            if (e_in.instr.valid && (e_in.instr.op == op_mul)) begin
                prod_q <= e_in.a * e_in.b;
            end
            // move on only with the owning instruction
            if (m1_in.instr.valid && (m1_in.instr.op == op_mul)) begin
                m2_product <= prod_q;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bypass.sv ====
`default_nettype none

module bypass import common_pkg::*, pipes_pkg::*; (
    input  bypass_input_t  [lanes-1:0] dataE_in,
    input  bypass_input_t  [lanes-1:0] dataM1_in,
    input  bypass_input_t  [lanes-1:0] dataM2_in,
    input  bypass_issue_t  [lanes-1:0] dataI_in,
    output bypass_output_t [lanes-1:0] outra1,
    output bypass_output_t [lanes-1:0] outra2
);

    // number of write sources scanned per operand
    localparam int src_cnt = 3 * lanes;

    // sources in priority order
    // E0, E1, M1_0, M1_1, M2_0, M2_1
    bypass_input_t [src_cnt-1:0] srcs;

    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            srcs[l]           = dataE_in[l];
            srcs[lanes + l]   = dataM1_in[l];
            srcs[2*lanes + l] = dataM2_in[l];
        end
    end

    // does source s write the register being read
    function automatic logic hit(bypass_input_t s, creg_addr_t ra);
        // r0 is never forwarded
        return s.regwrite && (s.rdst == ra) && (ra != '0);
    endfunction

    // first matching source wins
    function automatic bypass_output_t resolve(
        bypass_input_t [src_cnt-1:0] src,
        creg_addr_t                  ra
    );
        bypass_output_t res;
        logic           found;
        logic           in_m2;
        // default: no match, register file value is current
        res.valid  = 1'b1;
        res.bypass = 1'b0;
        res.data   = '0;
        found      = 1'b0;
        for (int s = 0; s < src_cnt; s++) begin
            in_m2 = (s >= 2 * lanes);
            if (!found && hit(src[s], ra)) begin
                found = 1'b1;
                // in M2 the final result is always there
                if (in_m2) begin
                    res.valid  = 1'b1;
                    res.bypass = 1'b1;
                end else begin
                    // a late write in E or M1 blocks the read
                    res.valid  = ~src[s].late;
                    res.bypass = ~src[s].late;
                end
                res.data = src[s].data;
            end
        end
        return res;
    endfunction

    // one resolver per lane and per source operand
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        always_comb begin
            outra1[i] = resolve(srcs, dataI_in[i].ra1);
        end

        always_comb begin
            outra2[i] = resolve(srcs, dataI_in[i].ra2);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/common_pkg.sv ====
`default_nettype none

package common_pkg;

    // datapath width
    localparam int data_w = 32;

    // architectural register count
    localparam int reg_cnt = 32;

    // issue width of the pipeline
    localparam int lanes = 2;

    // register index, r0 is hardwired zero
    typedef logic [$clog2(reg_cnt)-1:0] creg_addr_t;

    // one data word
    typedef logic [data_w-1:0] word_t;

    // lane opcodes
    // op_mul is the only late op, its result shows up in M2
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_addi,
        op_mul
    } op_t;

endpackage

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`default_nettype none

module issue_stage import common_pkg::*, pipes_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  instr_t         [lanes-1:0]    in_bundle,
    input  word_t          [2*lanes-1:0]  rf_data,
    input  bypass_output_t [lanes-1:0]    outra1,
    input  bypass_output_t [lanes-1:0]    outra2,
    output logic                          stall,
    output bypass_issue_t  [lanes-1:0]    dataI,
    output stage_t         [lanes-1:0]    issued
);

    // held bundle, slot 0 is the older one
    instr_t [lanes-1:0] slot_q;
    logic   [lanes-1:0] uses_b;
    logic   [lanes-1:0] ops_ok;
    logic               same_dep;
    logic               lane0_clear;
    logic               go0;
    logic               go1;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            // addi takes the immediate, ra2 unused
            uses_b[i]    = (slot_q[i].op != op_addi);
            ops_ok[i]    = outra1[i].valid && (outra2[i].valid || !uses_b[i]);
            dataI[i].ra1 = slot_q[i].ra1;
            dataI[i].ra2 = slot_q[i].ra2;
        end
    end

    // same bundle check
    // lane 1 reading lane 0's rdst has to wait for the forward path
    // equal rdst is split too, E0 would otherwise win over the newer E1
    assign same_dep = slot_q[0].valid && (slot_q[0].rdst != '0) &&
                      ((slot_q[1].ra1 == slot_q[0].rdst) ||
                       (uses_b[1] && (slot_q[1].ra2 == slot_q[0].rdst)) ||
                       (slot_q[1].rdst == slot_q[0].rdst));

    // lane 0 gates everything
    assign go0         = slot_q[0].valid && ops_ok[0];
    assign lane0_clear = !slot_q[0].valid || ops_ok[0];
    assign go1         = lane0_clear && slot_q[1].valid && ops_ok[1] && !same_dep;

    // any held instruction left behind holds the source
    assign stall = (slot_q[0].valid && !go0) || (slot_q[1].valid && !go1);

    // operand select, forwarded data or register file
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            issued[i].instr       = slot_q[i];
            issued[i].instr.valid = (i == 0) ? go0 : go1;
            issued[i].a           = outra1[i].bypass ? outra1[i].data : rf_data[2*i];
            if (!uses_b[i]) begin
                issued[i].b = {{(data_w-16){slot_q[i].imm[15]}}, slot_q[i].imm};
            end else if (outra2[i].bypass) begin
                issued[i].b = outra2[i].data;
            end else begin
                issued[i].b = rf_data[2*i+1];
            end
            issued[i].result      = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (!stall) begin
            // whole bundle gone, take the next one
            if (in_valid) begin
                slot_q <= in_bundle;
            end else begin
                slot_q <= '0;
            end
        end else if (go0) begin
            // split, lane 1 becomes the head
            slot_q[0] <= slot_q[1];
            slot_q[1] <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_core.sv ====
`default_nettype none

module pipe_core import common_pkg::*, pipes_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  instr_t  [lanes-1:0]    in_bundle,
    output logic                   stall,
    output retire_t [lanes-1:0]    retire
);

    // stage registers
    stage_t [lanes-1:0] e_q;
    stage_t [lanes-1:0] m1_q;
    stage_t [lanes-1:0] m2_q;

    // issue side
    stage_t         [lanes-1:0]   issued;
    bypass_issue_t  [lanes-1:0]   dataI;
    bypass_output_t [lanes-1:0]   outra1;
    bypass_output_t [lanes-1:0]   outra2;
    creg_addr_t     [2*lanes-1:0] rf_addr;
    word_t          [2*lanes-1:0] rf_data;

    // alu side
    word_t [lanes-1:0] e_result;
    word_t [lanes-1:0] m2_product;
    word_t [lanes-1:0] m2_data;

    // forwarding records
    bypass_input_t [lanes-1:0] byp_e;
    bypass_input_t [lanes-1:0] byp_m1;
    bypass_input_t [lanes-1:0] byp_m2;

    // pack one stage into a bypass record
    function automatic bypass_input_t to_byp(stage_t s, word_t d);
        bypass_input_t r;
        // r0 writes never forward
        r.regwrite = s.instr.valid && (s.instr.rdst != '0);
        r.late     = (s.instr.op == op_mul);
        r.rdst     = s.instr.rdst;
        r.data     = d;
        return r;
    endfunction

    issue_stage u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bundle (in_bundle),
        .rf_data   (rf_data),
        .outra1    (outra1),
        .outra2    (outra2),
        .stall     (stall),
        .dataI     (dataI),
        .issued    (issued)
    );

    // port order is lane 0 ra1, lane 0 ra2, lane 1 ra1, lane 1 ra2
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            rf_addr[2*i]   = dataI[i].ra1;
            rf_addr[2*i+1] = dataI[i].ra2;
        end
    end

    regfile u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (rf_addr),
        .wr    (retire),
        .rdata (rf_data)
    );

    for (genvar i = 0; i < lanes; i++) begin : g_alu
        alu_lane u_alu (
            .clk        (clk),
            .rst_n      (rst_n),
            .e_in       (e_q[i]),
            .m1_in      (m1_q[i]),
            .e_result   (e_result[i]),
            .m2_product (m2_product[i])
        );
    end

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            // mul gets its value only in M2
            m2_data[i] = (m2_q[i].instr.op == op_mul) ? m2_product[i] : m2_q[i].result;
            byp_e[i]   = to_byp(e_q[i], e_result[i]);
            byp_m1[i]  = to_byp(m1_q[i], m1_q[i].result);
            byp_m2[i]  = to_byp(m2_q[i], m2_data[i]);
            // writeback record
            // r0 destinations do not retire as writes
            retire[i].valid = m2_q[i].instr.valid && (m2_q[i].instr.rdst != '0);
            retire[i].rdst  = m2_q[i].instr.rdst;
            retire[i].data  = m2_data[i];
        end
    end

    bypass u_bypass (
        .dataE_in  (byp_e),
        .dataM1_in (byp_m1),
        .dataM2_in (byp_m2),
        .dataI_in  (dataI),
        .outra1    (outra1),
        .outra2    (outra2)
    );

    // E, M1, M2 advance every cycle, no back-pressure past issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q  <= '0;
            m1_q <= '0;
            m2_q <= '0;
        end else begin
            e_q <= issued;
            for (int i = 0; i < lanes; i++) begin
                m1_q[i]        <= e_q[i];
                m1_q[i].result <= e_result[i];
            end
            m2_q <= m1_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipes_pkg.sv ====
`default_nettype none

package pipes_pkg;

    import common_pkg::*;

    // one decoded instruction as it enters the issue stage
    typedef struct packed {
        logic              valid;
        op_t               op;
        creg_addr_t        rdst;
        creg_addr_t        ra1;
        creg_addr_t        ra2;
        // sign extended to a full word for op_addi
        logic signed [15:0] imm;
    } instr_t;

    // source registers of one lane in the issue stage
    typedef struct packed {
        creg_addr_t ra1;
        creg_addr_t ra2;
    } bypass_issue_t;

    // pending write from one lane of one stage
    typedef struct packed {
        logic       regwrite;
        // result not ready before M2
        logic       late;
        creg_addr_t rdst;
        word_t      data;
    } bypass_input_t;

    // resolved operand for one source read
    typedef struct packed {
        // operand can be used this cycle
        logic  valid;
        // take data instead of the register file
        logic  bypass;
        word_t data;
    } bypass_output_t;

    // contents of the E, M1 and M2 stage registers
    typedef struct packed {
        instr_t instr;
        word_t  a;
        word_t  b;
        // alu result, filled on the E to M1 edge
        word_t  result;
    } stage_t;

    // writeback record, also the retire observation
    typedef struct packed {
        logic       valid;
        creg_addr_t rdst;
        word_t      data;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none

module regfile import common_pkg::*, pipes_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  creg_addr_t [2*lanes-1:0]    raddr,
    input  retire_t    [lanes-1:0]      wr,
    output word_t      [2*lanes-1:0]    rdata
);

    // architectural state
    word_t regs [reg_cnt];

    // asynchronous read
    // r0 reads zero whatever is stored
    always_comb begin
        for (int p = 0; p < 2 * lanes; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

    // write on the edge that ends M2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < reg_cnt; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later lane is written last, so lane 1 wins a collision
            for (int l = 0; l < lanes; l++) begin
                if (wr[l].valid && (wr[l].rdst != '0)) begin
                    regs[wr[l].rdst] <= wr[l].data;
                end
            end
        end
    end

endmodule

`default_nettype wire
